// ==== dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// address and line geometry
`define DC_ADDR_BITS   32
`define DC_LINES       8
`define DC_LINE_BYTES  8

// derived field widths of a byte address
`define DC_INDEX_BITS  3    // log2 of DC_LINES
`define DC_OFFSET_BITS 3    // log2 of DC_LINE_BYTES
`define DC_TAG_BITS    26   // bits above index and offset

// memory bus
`define MEM_TAG_BITS   4    // response tag, zero means idle

`endif

// ==== mem_bus_pkg.sv ====
`include "dcache_settings.svh"

package mem_bus_pkg;

    // command encoding on the memory bus
    typedef enum logic [1:0] {
        bus_none  = 2'b00,
        bus_load  = 2'b01,
        bus_store = 2'b10
    } bus_cmd_t;

    // one line of data, with byte, half and word views
    typedef union packed {
        logic [`DC_LINE_BYTES-1:0][7:0]    byte_level;
        logic [`DC_LINE_BYTES/2-1:0][15:0] half_level;
        logic [`DC_LINE_BYTES/4-1:0][31:0] word_level;
    } line_block_t;

    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;  // zero means no response

    typedef logic [`DC_ADDR_BITS-1:0] mem_addr_t;  // byte address

endpackage

// ==== dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

    // access width of a pipeline request
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_t;

    // address fields
    typedef logic [`DC_TAG_BITS-1:0]    line_tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]  line_index_t;
    typedef logic [`DC_OFFSET_BITS-1:0] line_offset_t;

    // one entry of the line array
    typedef struct packed {
        logic                     valid;
        logic                     dirty;  // line differs from memory
        line_tag_t                tag;
        mem_bus_pkg::line_block_t block;
    } cache_line_t;

    // miss handler FSM
    typedef enum logic [1:0] {
        st_ready      = 2'b00,
        st_write_back = 2'b01,  // dirty victim goes out first
        st_load_issue = 2'b10,
        st_load_wait  = 2'b11   // load accepted, waiting for tagged data
    } miss_state_t;

endpackage

// ==== cache_req_if.sv ====
`timescale 1ns/1ps

// pipeline request as seen by the cache, held while stall is high
interface cache_req_if;

    logic                     valid;
    mem_bus_pkg::mem_addr_t   addr;
    dcache_pkg::access_size_t size;
    dcache_pkg::mem_op_t      op;
    logic [31:0]              write_data;

    // tag compare, store merge and refill placement
    modport lookup (
        input valid, addr, size, op, write_data
    );

    // miss logic only needs the line address
    modport miss (
        input addr
    );

endinterface

// ==== line_fill_if.sv ====
`timescale 1ns/1ps

interface line_fill_if;

    logic                     miss;          // one cycle per new miss
    logic                     victim_valid;
    logic                     victim_dirty;
    dcache_pkg::line_tag_t    victim_tag;
    mem_bus_pkg::line_block_t victim_block;

    logic                     fill_valid;    // write fill_block into the held line
    mem_bus_pkg::line_block_t fill_block;

    modport lookup (
        output miss, victim_valid, victim_dirty, victim_tag, victim_block,
        input  fill_valid, fill_block
    );

    modport refill (
        input  miss, victim_valid, victim_dirty, victim_tag, victim_block,
        output fill_valid, fill_block
    );

endinterface

// ==== line_store.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module line_store (
    input  logic                     clock,
    input  logic                     reset,
    cache_req_if.lookup              req,
    line_fill_if.lookup              fill,
    input  logic                     stall,
    output logic                     hit,
    output mem_bus_pkg::line_block_t hit_block
);

    dcache_pkg::cache_line_t  lines [`DC_LINES];

    dcache_pkg::line_tag_t    req_tag;
    dcache_pkg::line_index_t  req_index;
    dcache_pkg::line_offset_t req_offset;
    dcache_pkg::cache_line_t  cur_line;
    logic                     tag_match;
    mem_bus_pkg::line_block_t merged_block;

    // split the request address
    assign req_offset = req.addr[`DC_OFFSET_BITS-1:0];
    assign req_index  = req.addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign req_tag    = req.addr[`DC_ADDR_BITS-1 -: `DC_TAG_BITS];

    assign cur_line  = lines[req_index];
    assign tag_match = cur_line.valid && (cur_line.tag == req_tag);

    // while stalled the held request is being served by the miss handler
    assign hit       = req.valid && !stall && tag_match;
    assign fill.miss = req.valid && !stall && !tag_match;

    assign hit_block = cur_line.block;  // value before any store merge

    // the indexed line is the victim on a miss
    assign fill.victim_valid = cur_line.valid;
    assign fill.victim_dirty = cur_line.dirty;
    assign fill.victim_tag   = cur_line.tag;
    assign fill.victim_block = cur_line.block;

    // store data placed into the line by size and offset
    always_comb begin
        merged_block = cur_line.block;
        case (req.size)
            dcache_pkg::size_byte: begin
                merged_block.byte_level[req_offset] = req.write_data[7:0];
            end
            dcache_pkg::size_half: begin
                merged_block.half_level[req_offset[`DC_OFFSET_BITS-1:1]] =
                    req.write_data[15:0];
            end
            default: begin
                merged_block.word_level[req_offset[`DC_OFFSET_BITS-1]] = req.write_data;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else if (fill.fill_valid) begin
            // refilled line comes in clean
            lines[req_index] <= '{
                valid: 1'b1,
                dirty: 1'b0,
                tag:   req_tag,
                block: fill.fill_block
            };
        end else if (hit && (req.op == dcache_pkg::op_write)) begin
            lines[req_index].block <= merged_block;
            lines[req_index].dirty <= 1'b1;  // write-back, memory now stale
        end
    end

endmodule

// ==== miss_handler.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module miss_handler (
    input  logic                     clock,
    input  logic                     reset,
    cache_req_if.miss                req,
    line_fill_if.refill              fill,
    output logic                     stall,
    output mem_bus_pkg::bus_cmd_t    mem_command,
    output mem_bus_pkg::mem_addr_t   mem_addr,
    output mem_bus_pkg::line_block_t mem_write_data,
    input  mem_bus_pkg::mem_tag_t    mem_response,
    input  mem_bus_pkg::line_block_t mem_read_data,
    input  mem_bus_pkg::mem_tag_t    mem_read_tag
);

    dcache_pkg::miss_state_t state;
    dcache_pkg::miss_state_t next_state;
    mem_bus_pkg::mem_tag_t   load_tag;  // tag returned when the load was accepted

    dcache_pkg::line_index_t req_index;
    mem_bus_pkg::mem_addr_t  line_addr;
    mem_bus_pkg::mem_addr_t  victim_addr;
    logic                    accepted;
    logic                    load_done;

    assign req_index = req.addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];

    // line-aligned addresses of the missing line and of the victim
    assign line_addr   = {req.addr[`DC_ADDR_BITS-1:`DC_OFFSET_BITS],
                          {`DC_OFFSET_BITS{1'b0}}};
    assign victim_addr = {fill.victim_tag, req_index, {`DC_OFFSET_BITS{1'b0}}};

    assign accepted  = (mem_response != '0);
    assign load_done = (state == dcache_pkg::st_load_wait) &&
                       (mem_read_tag != '0) && (mem_read_tag == load_tag);

    assign stall = (state != dcache_pkg::st_ready);

    assign fill.fill_valid = load_done;
    assign fill.fill_block = mem_read_data;

    always_comb begin
        next_state     = state;
        mem_command    = mem_bus_pkg::bus_none;
        mem_addr       = line_addr;
        mem_write_data = fill.victim_block;  // only meaningful with a store
        case (state)
            dcache_pkg::st_ready: begin
                if (fill.miss) begin
                    if (fill.victim_valid && fill.victim_dirty) begin
                        next_state = dcache_pkg::st_write_back;
                    end else begin
                        next_state = dcache_pkg::st_load_issue;
                    end
                end
            end
            dcache_pkg::st_write_back: begin
                // victim line stays readable, the held request keeps its index
                mem_command = mem_bus_pkg::bus_store;
                mem_addr    = victim_addr;
                if (accepted) begin
                    next_state = dcache_pkg::st_load_issue;
                end
            end
            dcache_pkg::st_load_issue: begin
                mem_command = mem_bus_pkg::bus_load;  // repeated until accepted
                if (accepted) begin
                    next_state = dcache_pkg::st_load_wait;
                end
            end
            dcache_pkg::st_load_wait: begin
                if (load_done) begin
                    next_state = dcache_pkg::st_ready;  // request hits next cycle
                end
            end
            default: begin
                next_state = dcache_pkg::st_ready;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= dcache_pkg::st_ready;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if ((state == dcache_pkg::st_load_issue) && accepted) begin
            load_tag <= mem_response;
        end
    end

endmodule

// ==== response_align.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module response_align (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      hit,
    input  mem_bus_pkg::line_block_t  block,
    input  logic [`DC_OFFSET_BITS-1:0] offset,
    input  dcache_pkg::access_size_t  size,
    output logic                      resp_valid,
    output logic [31:0]               resp_data
);

    logic [31:0] aligned;

    // pick the sized field and zero-extend
    always_comb begin
        case (size)
            dcache_pkg::size_byte: aligned = {24'b0, block.byte_level[offset]};
            dcache_pkg::size_half: begin
                aligned = {16'b0, block.half_level[offset[`DC_OFFSET_BITS-1:1]]};
            end
            default:               aligned = block.word_level[offset[`DC_OFFSET_BITS-1]];
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= hit;  // one pulse per completed request
        end
    end

    always_ff @(posedge clock) begin
        if (hit) begin
            resp_data <= aligned;
        end
    end

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req_valid,
    input  mem_bus_pkg::mem_addr_t   req_addr,
    input  dcache_pkg::access_size_t req_size,
    input  dcache_pkg::mem_op_t      req_op,
    input  logic [31:0]              req_write_data,
    output logic                     stall,
    output logic                     resp_valid,
    output logic [31:0]              resp_data,
    output mem_bus_pkg::bus_cmd_t    mem_command,
    output mem_bus_pkg::mem_addr_t   mem_addr,
    output mem_bus_pkg::line_block_t mem_write_data,
    input  mem_bus_pkg::mem_tag_t    mem_response,
    input  mem_bus_pkg::line_block_t mem_read_data,
    input  mem_bus_pkg::mem_tag_t    mem_read_tag
);

    cache_req_if req_bus ();
    line_fill_if fill_bus ();

    logic                     lookup_hit;
    mem_bus_pkg::line_block_t lookup_block;

    assign req_bus.valid      = req_valid;
    assign req_bus.addr       = req_addr;
    assign req_bus.size       = req_size;
    assign req_bus.op         = req_op;
    assign req_bus.write_data = req_write_data;

    line_store u_line_store (
        .clock     (clock),
        .reset     (reset),
        .req       (req_bus),
        .fill      (fill_bus),
        .stall     (stall),
        .hit       (lookup_hit),
        .hit_block (lookup_block)
    );

    miss_handler u_miss_handler (
        .clock          (clock),
        .reset          (reset),
        .req            (req_bus),
        .fill           (fill_bus),
        .stall          (stall),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data),
        .mem_response   (mem_response),
        .mem_read_data  (mem_read_data),
        .mem_read_tag   (mem_read_tag)
    );

    response_align u_response_align (
        .clock      (clock),
        .reset      (reset),
        .hit        (lookup_hit),
        .block      (lookup_block),
        .offset     (req_addr[`DC_OFFSET_BITS-1:0]),  // byte within the line
        .size       (req_size),
        .resp_valid (resp_valid),
        .resp_data  (resp_data)
    );

endmodule

// ==== tb_memory.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

// line-wide memory, accepts with a nonzero tag after a random wait
module tb_memory (
    input  logic                     clock,
    input  logic                     reset,
    input  mem_bus_pkg::bus_cmd_t    mem_command,
    input  mem_bus_pkg::mem_addr_t   mem_addr,
    input  mem_bus_pkg::line_block_t mem_write_data,
    output mem_bus_pkg::mem_tag_t    mem_response,
    output mem_bus_pkg::line_block_t mem_read_data,
    output mem_bus_pkg::mem_tag_t    mem_read_tag,
    output int                       store_count,
    output mem_bus_pkg::mem_addr_t   last_store_addr,
    output mem_bus_pkg::line_block_t last_store_data
);

    logic [7:0]             bytes_written [logic [31:0]];
    int                     seed = 32'h2514;
    int                     wait_cycles;   // cycles the current command has waited
    int                     accept_delay;
    int                     data_delay;
    mem_bus_pkg::mem_tag_t  next_tag;
    logic                   pending;       // one load in flight
    mem_bus_pkg::mem_addr_t pending_addr;
    mem_bus_pkg::mem_tag_t  pending_tag;

    // bytes never stored follow the fill pattern of the whole address
    function automatic logic [7:0] byte_at(logic [31:0] addr);
        if (bytes_written.exists(addr)) begin
            return bytes_written[addr];
        end
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h96;
    endfunction

    function automatic mem_bus_pkg::line_block_t read_line(logic [31:0] addr);
        mem_bus_pkg::line_block_t blk;
        for (logic [3:0] i = 4'd0; i < 4'd8; i++) begin
            blk.byte_level[i[2:0]] = byte_at(addr + {29'b0, i[2:0]});
        end
        return blk;
    endfunction

    assign mem_response = (mem_command != mem_bus_pkg::bus_none && wait_cycles == accept_delay)
                          ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            wait_cycles   <= 0;
            accept_delay  <= 0;
            next_tag      <= 4'h1;
            pending       <= 1'b0;
            mem_read_tag  <= '0;
            mem_read_data <= '0;
            store_count   <= 0;
        end else begin
            mem_read_tag <= '0;
            if (mem_response != '0) begin
                wait_cycles  <= 0;
                accept_delay <= $random(seed) & 3;
                next_tag     <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;  // zero is idle
                if (mem_command == mem_bus_pkg::bus_store) begin
                    for (logic [3:0] i = 4'd0; i < 4'd8; i++) begin
                        bytes_written[mem_addr + {29'b0, i[2:0]}] =
                            mem_write_data.byte_level[i[2:0]];
                    end
                    store_count     <= store_count + 1;  // store log
                    last_store_addr <= mem_addr;
                    last_store_data <= mem_write_data;
                end else begin
                    pending      <= 1'b1;
                    pending_addr <= mem_addr;
                    pending_tag  <= mem_response;
                    data_delay   <= $random(seed) & 3;
                end
            end else if (mem_command != mem_bus_pkg::bus_none) begin
                wait_cycles <= wait_cycles + 1;
            end
            if (pending) begin
                if (data_delay == 0) begin
                    mem_read_tag  <= pending_tag;
                    mem_read_data <= read_line(pending_addr);
                    pending       <= 1'b0;
                end else begin
                    data_delay <= data_delay - 1;
                end
            end
        end
    end

endmodule

// ==== dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;

    typedef struct packed {
        int                       test_id;
        dcache_pkg::mem_op_t      op;
        dcache_pkg::access_size_t size;
        logic [31:0]              addr;
        logic [31:0]              write_data;
        logic [31:0]              expected;     // load value from the shadow model
        int                       mem_check;    // 1 no memory traffic, 2 one write-back
        logic [31:0]              victim_addr;
        logic [63:0]              victim_line;
    } stim_entry_t;

    logic                     clock = 1'b0;
    logic                     reset;
    logic                     req_valid;
    mem_bus_pkg::mem_addr_t   req_addr;
    dcache_pkg::access_size_t req_size;
    dcache_pkg::mem_op_t      req_op;
    logic [31:0]              req_write_data;
    logic                     stall;
    logic                     resp_valid;
    logic [31:0]              resp_data;
    mem_bus_pkg::bus_cmd_t    mem_command;
    mem_bus_pkg::mem_addr_t   mem_addr;
    mem_bus_pkg::line_block_t mem_write_data;
    mem_bus_pkg::mem_tag_t    mem_response;
    mem_bus_pkg::line_block_t mem_read_data;
    mem_bus_pkg::mem_tag_t    mem_read_tag;
    int                       store_count;
    mem_bus_pkg::mem_addr_t   last_store_addr;
    mem_bus_pkg::line_block_t last_store_data;

    stim_entry_t stim [$];
    logic [7:0]  shadow [logic [31:0]];  // architected byte values
    int          seed = 32'h2514;
    int          checks_run = 0;
    int          checks_failed = 0;
    int          test_failed = 0;
    int          command_cycles = 0;
    logic        timed_out = 1'b0;

    dcache_top dut_i (.*);
    tb_memory  mem_i (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        if (mem_command != mem_bus_pkg::bus_none) begin
            command_cycles <= command_cycles + 1;
        end
    end

    function automatic logic [7:0] shadow_byte(logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h96;  // fill pattern
    endfunction

    // little-endian value of nbytes starting at addr
    function automatic logic [31:0] shadow_value(logic [31:0] addr, int nbytes);
        logic [31:0] value;
        value = '0;
        for (int i = nbytes - 1; i >= 0; i--) begin
            value = {value[23:0], shadow_byte(addr + i)};
        end
        return value;
    endfunction

    function automatic int size_bytes(dcache_pkg::access_size_t size);
        if (size == dcache_pkg::size_byte) begin
            return 1;
        end
        return (size == dcache_pkg::size_half) ? 2 : 4;
    endfunction

    task automatic add_entry(int test_id, dcache_pkg::mem_op_t op,
                             dcache_pkg::access_size_t size, logic [31:0] addr,
                             logic [31:0] write_data, int mem_check, logic [31:0] victim);
        stim_entry_t e;
        logic [31:0] data;
        e             = '0;
        e.test_id     = test_id;
        e.op          = op;
        e.size        = size;
        e.addr        = addr;
        e.write_data  = write_data;
        e.expected    = shadow_value(addr, size_bytes(size));
        e.mem_check   = mem_check;
        e.victim_addr = victim;
        e.victim_line = {shadow_value(victim + 4, 4), shadow_value(victim, 4)};
        data          = write_data;
        if (op == dcache_pkg::op_write) begin
            for (int i = 0; i < size_bytes(size); i++) begin
                shadow[addr + i] = data[7:0];
                data = data >> 8;
            end
        end
        stim.push_back(e);
    endtask

    task automatic build_table();
        int                       pick;
        int                       offset;
        logic [31:0]              tag_base;
        dcache_pkg::access_size_t size;
        dcache_pkg::mem_op_t      op;
        add_entry(2, dcache_pkg::op_read, dcache_pkg::size_word, 32'h2010, 0, 0, 0);
        add_entry(2, dcache_pkg::op_read, dcache_pkg::size_word, 32'h2014, 0, 1, 0);
        // write-allocate, then merges of each size
        add_entry(3, dcache_pkg::op_write, dcache_pkg::size_word, 32'h2028, 32'ha1b2c3d4, 0, 0);
        add_entry(3, dcache_pkg::op_write, dcache_pkg::size_half, 32'h202a, 32'h5566, 0, 0);
        add_entry(3, dcache_pkg::op_write, dcache_pkg::size_byte, 32'h202d, 32'h7e, 0, 0);
        add_entry(3, dcache_pkg::op_read, dcache_pkg::size_byte, 32'h2028, 0, 0, 0);
        add_entry(3, dcache_pkg::op_read, dcache_pkg::size_half, 32'h202a, 0, 0, 0);
        add_entry(3, dcache_pkg::op_read, dcache_pkg::size_word, 32'h2028, 0, 0, 0);
        add_entry(3, dcache_pkg::op_read, dcache_pkg::size_word, 32'h202c, 0, 0, 0);
        add_entry(3, dcache_pkg::op_read, dcache_pkg::size_byte, 32'h202d, 0, 0, 0);
        add_entry(3, dcache_pkg::op_read, dcache_pkg::size_half, 32'h202e, 0, 0, 0);
        // dirty line at index 6 evicted by another tag
        add_entry(4, dcache_pkg::op_write, dcache_pkg::size_word, 32'h2030, 32'hcafe0001, 0, 0);
        add_entry(4, dcache_pkg::op_read, dcache_pkg::size_word, 32'h46030, 0, 2, 32'h2030);
        add_entry(4, dcache_pkg::op_read, dcache_pkg::size_word, 32'h2030, 0, 0, 0);
        for (int n = 0; n < 30; n++) begin
            pick     = $random(seed) & 3;
            offset   = $random(seed) & 7;
            tag_base = (($random(seed) & 1) != 0) ? 32'h0004_6000 : 32'h0000_2000;
            size     = (pick == 0) ? dcache_pkg::size_byte :
                       (pick == 1) ? dcache_pkg::size_half : dcache_pkg::size_word;
            op       = (($random(seed) & 1) != 0) ? dcache_pkg::op_write : dcache_pkg::op_read;
            offset   = offset & ~(size_bytes(size) - 1);  // natural alignment
            add_entry(5, op, size, tag_base + ((($random(seed) & 7) << 3) + offset),
                      $random(seed), 0, 0);
        end
    endtask

    task automatic check_equal(string name, logic [63:0] got, logic [63:0] expected);
        checks_run++;
        assert (got == expected) else begin
            $display("Fail at %0t: %s got %0h, expected %0h", $time, name, got, expected);
            checks_failed++;
            test_failed++;
        end
    endtask

    task automatic wait_stall_low();
        int cycles;
        cycles = 0;
        while (stall && !timed_out) begin
            @(negedge clock);
            cycles++;
            if (cycles >= 200) begin
                $display("timeout: stall stayed high for 200 cycles at %0t", $time);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_response();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles >= 200 && !resp_valid) begin
                $display("timeout: no response within 200 cycles at %0t", $time);
                timed_out = 1'b1;
            end
        end while (!resp_valid && !timed_out);
    endtask

    // called on a falling edge, returns on the falling edge that shows resp_valid
    task automatic apply_entry(stim_entry_t e);
        int stores_before;
        int commands_before;
        wait_stall_low();
        stores_before   = store_count;
        commands_before = command_cycles;
        req_valid       = 1'b1;
        req_addr        = e.addr;
        req_size        = e.size;
        req_op          = e.op;
        req_write_data  = e.write_data;
        wait_response();
        req_valid = 1'b0;
        if (!timed_out) begin
            if (e.op == dcache_pkg::op_read) begin
                check_equal("resp_data", {32'b0, resp_data}, {32'b0, e.expected});
            end
            if (e.mem_check == 1) begin
                check_equal("mem_command cycles", {32'b0, command_cycles - commands_before}, 0);
            end
            if (e.mem_check == 2) begin
                check_equal("store count", {32'b0, store_count - stores_before}, 64'd1);
                check_equal("last_store_addr", {32'b0, last_store_addr}, {32'b0, e.victim_addr});
                check_equal("last_store_data", last_store_data, e.victim_line);
            end
        end
    endtask

    task automatic report_test(int test_id);
        $display("test %0d: %s", test_id, (test_failed == 0) ? "ok" : "errors found");
        test_failed = 0;
    endtask

    initial begin
        reset          = 1'b1;
        req_valid      = 1'b0;
        req_addr       = '0;
        req_size       = dcache_pkg::size_word;
        req_op         = dcache_pkg::op_read;
        req_write_data = '0;
        build_table();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        check_equal("stall", {63'b0, stall}, 64'd0);
        check_equal("resp_valid", {63'b0, resp_valid}, 64'd0);
        check_equal("mem_command", {62'b0, mem_command}, {62'b0, mem_bus_pkg::bus_none});
        report_test(1);
        foreach (stim[i]) begin
            if (!timed_out) begin
                apply_entry(stim[i]);
                if (i == stim.size() - 1 || stim[i + 1].test_id != stim[i].test_id) begin
                    report_test(stim[i].test_id);
                end
            end
        end
        $display("checks: %0d run, %0d failed", checks_run, checks_failed);
        if (checks_failed == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
mem_bus_pkg.sv
dcache_pkg.sv
cache_req_if.sv
line_fill_if.sv
line_store.sv
miss_handler.sv
response_align.sv
dcache_top.sv
tb_memory.sv
dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module dcache_tb \
    -Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict on a line of its own
if grep -q "^All checks passed$" sim.log; then
    exit 0
fi
exit 1
